// ==== source/patch_pkg.sv ====
package patch_pkg;

  localparam int win_bits     = 4;                        // log2 of the window size
  localparam int sync_window  = 2 ** win_bits;            // Patches per window
  localparam int win_cnt_bits = 8;                        // Run length in windows
  localparam int patch_bits   = win_bits + win_cnt_bits;  // Window field over slot field
  localparam int weight_bits  = 20;
  localparam int lfsr_bits    = 8;

  // Feedback taps of the scrambler, bits 7, 5, 4 and 3
  localparam logic [lfsr_bits-1:0] lfsr_taps = 8'hb8;

  typedef struct packed {
    logic [patch_bits-1:0]  patch_num;
    logic [weight_bits-1:0] weight;
  } patch_rec_t;

endpackage

// ==== source/patch_fifo.sv ====
module patch_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 16
) (
  input  logic     clk_200,
  input  logic     rst_n,
  input  logic     wr_en,
  input  payload_t din,
  output logic     full,
  input  logic     rd_en,
  output payload_t dout,
  output logic     empty
);

  payload_t                 mem [depth];
  logic [$clog2(depth):0]   wr_ptr;      // Extra top bit marks the wrap
  logic [$clog2(depth):0]   rd_ptr;
  logic                     do_wr;
  logic                     do_rd;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[$clog2(depth)] != rd_ptr[$clog2(depth)]) &&
                 (wr_ptr[$clog2(depth)-1:0] == rd_ptr[$clog2(depth)-1:0]);

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign dout = mem[rd_ptr[$clog2(depth)-1:0]];  // Show-ahead head

  always_ff @(posedge clk_200) begin
    if (do_wr) begin
      mem[wr_ptr[$clog2(depth)-1:0]] <= din;
    end
  end

  always_ff @(posedge clk_200 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

// ==== source/patch_source.sv ====
module patch_source (
  input  logic                               clk_200,
  input  logic                               rst_n,
  input  logic                               start,
  input  logic [patch_pkg::lfsr_bits-1:0]    seed,
  input  logic [patch_pkg::win_cnt_bits-1:0] n_windows,
  input  logic                               full,
  output logic                               wr_en,
  output patch_pkg::patch_rec_t              rec
);
  import patch_pkg::*;

  logic [lfsr_bits-1:0]    lfsr;
  logic [lfsr_bits-1:0]    lfsr_next;
  logic [win_bits-1:0]     pos;        // Arrival position inside the window
  logic [win_cnt_bits-1:0] win;        // Current window
  logic [win_cnt_bits-1:0] win_inc;
  logic                    win_last;
  logic                    active;

  // Shift left, new low bit is the inverted XOR of the tapped bits
  assign lfsr_next = {lfsr[lfsr_bits-2:0], ~^(lfsr & lfsr_taps)};
  assign win_last  = &pos;
  assign win_inc   = win + 1'b1;

  assign wr_en         = active && !full;
  assign rec.patch_num = {win, pos ^ lfsr[win_bits-1:0]};  // Scrambled inside the window
  assign rec.weight    = weight_bits'({win, pos});         // Arrival order in the run

  always_ff @(posedge clk_200 or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      lfsr   <= '0;
      pos    <= '0;
      win    <= '0;
    end else if (start) begin
      active <= (n_windows != '0);  // Empty run emits nothing
      lfsr   <= seed;
      pos    <= '0;
      win    <= '0;
    end else if (wr_en) begin
      pos <= pos + 1'b1;
      if (win_last) begin
        lfsr <= lfsr_next;          // New mask for the next window
        win  <= win_inc;
        if (win_inc == n_windows) begin
          active <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== source/patch_reorder.sv ====
module patch_reorder (
  input  logic                               clk_200,
  input  logic                               rst_n,
  input  logic                               start,
  input  logic [patch_pkg::win_cnt_bits-1:0] n_windows,
  input  logic                               empty,
  input  patch_pkg::patch_rec_t              head,
  output logic                               rd_en,
  output logic [patch_pkg::patch_bits-1:0]   out_patch,
  output logic [patch_pkg::weight_bits-1:0]  out_weight,
  output logic                               out_req,
  input  logic                               out_ack,
  output logic                               done
);
  import patch_pkg::*;

  logic [weight_bits-1:0] slot_weight [sync_window];
  logic [sync_window-1:0] slot_valid;
  logic [patch_bits-1:0]  next_num;    // Next patch number to release
  logic [patch_bits-1:0]  end_num;     // One past the last patch of the run
  logic [win_bits-1:0]    head_slot;
  logic [win_bits-1:0]    next_slot;
  logic                   busy;
  logic                   hs_idle;     // Previous output handshake complete
  logic                   launch;
  logic                   finish;

  assign end_num   = {n_windows, {win_bits{1'b0}}};
  assign head_slot = head.patch_num[win_bits-1:0];
  assign next_slot = next_num[win_bits-1:0];
  assign hs_idle   = !out_req && !out_ack;

  // Only records of the current window leave the FIFO
  assign rd_en  = busy && !empty &&
                  (head.patch_num[patch_bits-1:win_bits] == next_num[patch_bits-1:win_bits]);
  assign launch = busy && slot_valid[next_slot] && hs_idle;
  assign finish = busy && (next_num == end_num) && hs_idle;

  always_ff @(posedge clk_200) begin
    if (rd_en) begin
      slot_weight[head_slot] <= head.weight;
    end
  end

  always_ff @(posedge clk_200) begin
    if (launch) begin
      out_patch  <= next_num;
      out_weight <= slot_weight[next_slot];
    end
  end

  always_ff @(posedge clk_200 or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid <= '0;
      next_num   <= '0;
      busy       <= 1'b0;
      done       <= 1'b0;
      out_req    <= 1'b0;
    end else if (start) begin
      slot_valid <= '0;
      next_num   <= '0;
      busy       <= 1'b1;
      done       <= 1'b0;
    end else begin
      if (rd_en) begin
        slot_valid[head_slot] <= 1'b1;
      end
      // Slots within a window are distinct, so this never hits the slot written above
      if (launch) begin
        slot_valid[next_slot] <= 1'b0;
        next_num              <= next_num + 1'b1;
        out_req               <= 1'b1;
      end else if (out_req && out_ack) begin
        out_req <= 1'b0;
      end
      if (finish) begin
        busy <= 1'b0;
        done <= 1'b1;                // Held until the next run starts
      end
    end
  end

endmodule

// ==== source/patch_sort_top.sv ====
module patch_sort_top (
  input  logic                               clk_200,
  input  logic                               rst_n,
  input  logic                               run_req,
  output logic                               run_ack,
  input  logic [patch_pkg::lfsr_bits-1:0]    seed,
  input  logic [patch_pkg::win_cnt_bits-1:0] n_windows,
  output logic [patch_pkg::patch_bits-1:0]   out_patch,
  output logic [patch_pkg::weight_bits-1:0]  out_weight,
  output logic                               out_req,
  input  logic                               out_ack
);
  import patch_pkg::*;

  logic       run_req_d;
  logic       start;
  logic       done;
  logic       wr_en;
  logic       full;
  logic       rd_en;
  logic       empty;
  patch_rec_t src_rec;
  patch_rec_t head;

  assign start = run_req && !run_req_d;  // Rising edge of run_req

  always_ff @(posedge clk_200 or negedge rst_n) begin
    if (!rst_n) begin
      run_req_d <= 1'b0;
      run_ack   <= 1'b0;
    end else begin
      run_req_d <= run_req;
      run_ack   <= run_req && !start && done;  // Stale done of the last run is ignored
    end
  end

  patch_source patch_source_i (
    .clk_200   (clk_200),
    .rst_n     (rst_n),
    .start     (start),
    .seed      (seed),
    .n_windows (n_windows),
    .full      (full),
    .wr_en     (wr_en),
    .rec       (src_rec)
  );

  patch_fifo #(
    .payload_t (patch_rec_t),
    .depth     (16)
  ) patch_fifo_i (
    .clk_200 (clk_200),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .din     (src_rec),
    .full    (full),
    .rd_en   (rd_en),
    .dout    (head),
    .empty   (empty)
  );

  patch_reorder patch_reorder_i (
    .clk_200    (clk_200),
    .rst_n      (rst_n),
    .start      (start),
    .n_windows  (n_windows),
    .empty      (empty),
    .head       (head),
    .rd_en      (rd_en),
    .out_patch  (out_patch),
    .out_weight (out_weight),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .done       (done)
  );

endmodule

// ==== test/patch_sort_tb.sv ====
module patch_sort_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import patch_pkg::*;

  localparam int n_tests = 6;

  logic                    clk_200;
  logic                    rst_n;
  logic                    run_req;
  logic                    run_ack;
  logic [lfsr_bits-1:0]    seed;
  logic [win_cnt_bits-1:0] n_windows;
  logic [patch_bits-1:0]   out_patch;
  logic [weight_bits-1:0]  out_weight;
  logic                    out_req;
  logic                    out_ack;

  // Stimulus table, one row per run
  string                   test_name      [n_tests];
  logic [lfsr_bits-1:0]    test_seed      [n_tests];
  logic [win_cnt_bits-1:0] test_windows   [n_tests];
  int                      test_min_delay [n_tests];
  int                      test_max_delay [n_tests];

  int          error_count;
  int          check_count;
  int          record_count;
  int          cycle_count;
  int          timeout_limit;
  logic [31:0] rng_state;

  patch_sort_top patch_sort_top_i (
    .clk_200    (clk_200),
    .rst_n      (rst_n),
    .run_req    (run_req),
    .run_ack    (run_ack),
    .seed       (seed),
    .n_windows  (n_windows),
    .out_patch  (out_patch),
    .out_weight (out_weight),
    .out_req    (out_req),
    .out_ack    (out_ack)
  );

  always #5 clk_200 = ~clk_200;

  always @(posedge clk_200) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles, the run hung waiting on the DUT", cycle_count);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Shift left, new low bit is the inverted XOR of bits 7, 5, 4 and 3
  function automatic logic [7:0] lfsr_step(input logic [7:0] v);
    return {v[6:0], ~(v[7] ^ v[5] ^ v[4] ^ v[3])};
  endfunction

  // Weight is the arrival position, patch = w*16 + (k ^ mask)
  function automatic int model_weight(input logic [7:0] run_seed, input int patch);
    logic [7:0] state;
    int         window;
    int         mask;
    state  = run_seed;
    window = patch / sync_window;
    for (int i = 0; i < window; i++) begin
      state = lfsr_step(state);
    end
    mask = state[win_bits-1:0];
    return window * sync_window + ((patch % sync_window) ^ mask);
  endfunction

  function automatic int run_limit();
    int total;
    total = 200;
    for (int i = 0; i < n_tests; i++) begin
      total += test_windows[i] * sync_window * (test_max_delay[i] + 6);
    end
    return total;
  endfunction

  task automatic set_row(input int idx, input string name, input logic [7:0] s,
                         input logic [7:0] w, input int lo, input int hi);
    test_name[idx]      = name;
    test_seed[idx]      = s;
    test_windows[idx]   = w;
    test_min_delay[idx] = lo;
    test_max_delay[idx] = hi;
  endtask

  task automatic draw_delay(input int idx, output int delay);
    int span;
    span      = test_max_delay[idx] - test_min_delay[idx] + 1;
    rng_state = xorshift32(rng_state);
    delay     = test_min_delay[idx] + int'(rng_state % 32'(span));
  endtask

  task automatic check_idle_after_reset();
    repeat (4) begin
      @(posedge clk_200);
      check_count++;
      assert (!out_req && !run_ack) else begin
        error_count++;
        $display("out_req or run_ack went high after reset with no run requested");
      end
    end
  endtask

  task automatic run_test(input int idx);
    int expected_total;
    int got;
    int delay;
    int exp_weight;
    bit acked;
    expected_total = test_windows[idx] * sync_window;
    got            = 0;
    acked          = 1'b0;
    @(posedge clk_200);
    seed      <= test_seed[idx];
    n_windows <= test_windows[idx];
    run_req   <= 1'b1;
    while (!acked) begin
      @(posedge clk_200);
      if (run_ack) begin
        acked = 1'b1;
        check_count++;
        assert (got == expected_total) else begin  // run_ack only after the last record
          error_count++;
          $display("Mismatch %s record count: expected %0d, actual %0d",
                   test_name[idx], expected_total, got);
        end
      end else if (out_req && !out_ack) begin
        exp_weight = model_weight(test_seed[idx], got);
        check_count += 2;
        assert (int'(out_patch) == got) else begin
          error_count++;
          $display("Mismatch %s patch: expected %0d, actual %0d",
                   test_name[idx], got, out_patch);
        end
        assert (int'(out_weight) == exp_weight) else begin
          error_count++;
          $display("Mismatch %s weight of patch %0d: expected %0d, actual %0d",
                   test_name[idx], got, exp_weight, out_weight);
        end
        got++;
        draw_delay(idx, delay);
        repeat (delay) @(posedge clk_200);
        out_ack <= 1'b1;
        do @(posedge clk_200); while (out_req);  // Wait for the DUT to drop out_req
        out_ack <= 1'b0;
      end
    end
    record_count += got;
    run_req <= 1'b0;
    do @(posedge clk_200); while (run_ack);
    check_count++;
    assert (!out_req) else begin
      error_count++;
      $display("%s: DUT raised out_req after the run had ended", test_name[idx]);
    end
  endtask

  initial begin
    clk_200      = 1'b0;
    rst_n        = 1'b0;
    run_req      = 1'b0;
    seed         = '0;
    n_windows    = '0;
    out_ack      = 1'b0;
    error_count  = 0;
    check_count  = 0;
    record_count = 0;
    cycle_count  = 0;
    rng_state    = 32'd81791;
    set_row(0, "order_seed_00", 8'h00, 8'd3, 0, 2);
    set_row(1, "order_seed_a5", 8'ha5, 8'd4, 0, 3);
    set_row(2, "order_seed_ff", 8'hff, 8'd5, 1, 4);
    set_row(3, "back_pressure", 8'h3c, 8'd3, 5, 20);  // Slow host fills slots and FIFO
    set_row(4, "empty_run",     8'h11, 8'd0, 0, 1);
    set_row(5, "rerun_seed_a5", 8'ha5, 8'd2, 0, 0);   // Starts right after the last one
    timeout_limit = run_limit();
    repeat (3) @(posedge clk_200);
    rst_n <= 1'b1;
    check_idle_after_reset();
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("Summary: %0d runs, %0d records, %0d checks, %0d errors",
             n_tests, record_count, check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
source/patch_pkg.sv
source/patch_fifo.sv
source/patch_source.sv
source/patch_reorder.sv
source/patch_sort_top.sv
test/patch_sort_tb.sv
